// ==== include/img_settings.svh ====
`ifndef IMG_SETTINGS_SVH
`define IMG_SETTINGS_SVH

// ========================================================================
// Capture sizing
// ========================================================================

// Command header words, sent most significant first
`define IMG_HEADER_WORDS 8

// Words held by the send FIFO
`define IMG_FIFO_DEPTH 16

// Credits granted by the downstream writer after reset
`define IMG_CREDIT_MAX 4

// Word counter covers 256x256 pixels plus header and checksum
`define IMG_COUNT_W 17

// Highlight and shadow counters
`define IMG_STAT_W 18

`endif

// ==== sim.f ====
+incdir+include
src/img_data_pkg.sv
src/img_ctrl_pkg.sv
src/img_pixel_sampler.sv
src/img_block_stats.sv
src/fletcher_checksum.sv
src/img_capture_framer.sv
src/credit_word_sender.sv
src/img_capture_top.sv
tests/tb_img_capture.sv

// ==== src/credit_word_sender.sv ====
`timescale 1ns/1ps
`include "img_settings.svh"

module credit_word_sender (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  img_data_pkg::word_t push_data,
    output logic                full,
    input  logic                credit,
    output logic                out_valid,
    output img_data_pkg::word_t out_data
);
    import img_data_pkg::*;

    localparam int DEPTH  = `IMG_FIFO_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(`IMG_CREDIT_MAX + 1);

    word_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              wr_en;
    logic              pop;

    assign full  = (count == CNT_W'(DEPTH));
    assign wr_en = push && !full;
    // A word leaves only against a credit
    assign pop   = (count != '0) && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CRED_W'(`IMG_CREDIT_MAX);
            out_valid <= 1'b0;
        end else begin
            out_valid <= pop;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Send and returned credit in one cycle cancel
            case ({pop, credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

    // Downstream returns no more credits than words it received
    a_credit_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        credit |-> (credits < CRED_W'(`IMG_CREDIT_MAX)));

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(`IMG_CREDIT_MAX));

endmodule

// ==== src/fletcher_checksum.sv ====
`timescale 1ns/1ps

module fletcher_checksum (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear,
    input  logic                enable,
    input  img_data_pkg::word_t word,
    output logic [31:0]         sum
);
    import img_data_pkg::*;

    localparam logic [16:0] MODULUS = 17'd65535;

    word_t       swapped;
    logic [15:0] sum1;
    logic [15:0] sum2;
    logic [16:0] add1;
    logic [16:0] add2;
    logic [15:0] next1;
    logic [15:0] next2;

    // Host reads the stream little-endian
    assign swapped = {word[7:0], word[15:8]};

    // Both running sums stay below 65535
    assign add1  = {1'b0, sum1} + {1'b0, swapped};
    assign next1 = (add1 >= MODULUS) ? 16'(add1 - MODULUS) : add1[15:0];
    assign add2  = {1'b0, sum2} + {1'b0, next1};
    assign next2 = (add2 >= MODULUS) ? 16'(add2 - MODULUS) : add2[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (enable) begin
            sum1 <= next1;
            sum2 <= next2;
        end
    end

    assign sum = {sum2, sum1};

endmodule

// ==== src/img_block_stats.sv ====
`timescale 1ns/1ps
`include "img_settings.svh"

module img_block_stats (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      clear,
    input  img_data_pkg::pixel_beat_t beat,
    output logic [`IMG_STAT_W-1:0]    highlight_count,
    output logic [`IMG_STAT_W-1:0]    shadow_count
);
    import img_data_pkg::*;

    localparam int PIXEL_W = $bits(pixel_t);

    // Only the top seven bits decide the class
    logic [6:0] top_bits;

    assign top_bits = beat.data[PIXEL_W-1 -: 7];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (clear) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (beat.block_sample) begin
            // Saturated sample
            if (&top_bits) begin
                highlight_count <= highlight_count + 1'b1;
            end else if (~|top_bits) begin
                // Black sample
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

// ==== src/img_capture_framer.sv ====
`timescale 1ns/1ps
`include "img_settings.svh"

module img_capture_framer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          capture,
    input  img_data_pkg::header_t         header,
    input  img_data_pkg::pixel_beat_t     beat,
    input  logic                          full,
    output logic                          push,
    output img_data_pkg::word_t           push_data,
    output logic                          capture_done,
    output img_ctrl_pkg::capture_status_t status
);
    import img_data_pkg::*;
    import img_ctrl_pkg::*;

    localparam int HDR_CNT_W = $clog2(`IMG_HEADER_WORDS);
    localparam int WORD_W    = $bits(word_t);

    capture_state_t          state;
    header_t                 hdr_shift;
    logic [HDR_CNT_W-1:0]    hdr_left;
    logic [`IMG_COUNT_W-1:0] word_count;
    logic                    overflow;
    logic                    clear;
    logic                    in_frame;
    logic                    pix_word;
    logic                    sum_en;
    logic [31:0]             sum;
    logic [`IMG_STAT_W-1:0]  highlight_count;
    logic [`IMG_STAT_W-1:0]  shadow_count;
    pixel_beat_t             stats_beat;

    assign clear = (state == ST_CLEAR);

    // The first frame beat can carry a pixel before frame_rise shows up
    assign in_frame = (state == ST_PIXELS) || ((state == ST_WAIT_FRAME) && beat.frame);
    assign pix_word = in_frame && beat.valid && beat.frame;

    // ========================================================================
    // Word selection
    // ========================================================================
    always_comb begin
        push      = 1'b0;
        push_data = hdr_shift[$bits(header_t)-1 -: WORD_W];
        case (state)
            ST_HEADER: push = !full;
            ST_WAIT_FRAME, ST_PIXELS: begin
                // Pixel stored little-endian
                push      = pix_word && !full;
                push_data = {beat.data[7:0], 4'b0000, beat.data[11:8]};
            end
            ST_CHECKSUM_LO: begin
                push      = !full;
                push_data = {sum[7:0], sum[15:8]};
            end
            ST_CHECKSUM_HI: begin
                push      = !full;
                push_data = {sum[23:16], sum[31:24]};
            end
            default: push = 1'b0;
        endcase
    end

    // Checksum words are not folded into themselves
    assign sum_en = push && (state inside {ST_HEADER, ST_WAIT_FRAME, ST_PIXELS});

    // ========================================================================
    // Capture sequence
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            hdr_left     <= '0;
            word_count   <= '0;
            overflow     <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            capture_done <= 1'b0;
            if (push) begin
                word_count <= word_count + 1'b1;
            end
            // Sensor cannot stall, so a pixel meeting a full FIFO is lost
            if (pix_word && full) begin
                overflow <= 1'b1;
            end
            case (state)
                ST_CLEAR: begin
                    word_count <= '0;
                    overflow   <= 1'b0;
                    hdr_left   <= HDR_CNT_W'(`IMG_HEADER_WORDS - 1);
                    state      <= ST_HEADER;
                end
                ST_HEADER: begin
                    if (push && (hdr_left == '0)) begin
                        state <= ST_WAIT_IDLE;
                    end else if (push) begin
                        hdr_left <= hdr_left - 1'b1;
                    end
                end
                ST_WAIT_IDLE:   if (!beat.frame) state <= ST_WAIT_FRAME;
                ST_WAIT_FRAME:  if (beat.frame_rise) state <= ST_PIXELS;
                ST_PIXELS:      if (beat.frame_fall) state <= ST_CHECKSUM_LO;
                ST_CHECKSUM_LO: if (push) state <= ST_CHECKSUM_HI;
                ST_CHECKSUM_HI: begin
                    if (push) begin
                        capture_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (capture) begin
                state <= ST_CLEAR;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            hdr_shift <= header;
        end else if ((state == ST_HEADER) && push) begin
            hdr_shift <= hdr_shift << WORD_W;
        end
    end

    // Block statistics only see samples from the captured frame
    always_comb begin
        stats_beat              = beat;
        stats_beat.block_sample = beat.block_sample && in_frame;
    end

    fletcher_checksum u_checksum (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .enable (sum_en),
        .word   (push_data),
        .sum    (sum)
    );

    img_block_stats u_stats (
        .clk             (clk),
        .rst_n           (rst_n),
        .clear           (clear),
        .beat            (stats_beat),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    always_comb begin
        status.word_count      = word_count;
        status.highlight_count = highlight_count;
        status.shadow_count    = shadow_count;
        status.overflow        = overflow;
    end

    // Sender must have room for every word pushed
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

endmodule

// ==== src/img_capture_top.sv ====
`timescale 1ns/1ps

module img_capture_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // Sensor
    input  img_data_pkg::pixel_t          img_d,
    input  logic                          img_fv,
    input  logic                          img_lv,
    // Command
    input  logic                          capture,
    input  img_data_pkg::header_t         header,
    // Downstream link
    output logic                          out_valid,
    output img_data_pkg::word_t           out_data,
    input  logic                          credit,
    // Status
    output logic                          capture_done,
    output img_ctrl_pkg::capture_status_t status
);

    img_data_pkg::pixel_beat_t beat;
    img_data_pkg::word_t       push_data;
    logic                      push;
    logic                      full;

    img_pixel_sampler u_sampler (
        .clk    (clk),
        .rst_n  (rst_n),
        .img_d  (img_d),
        .img_fv (img_fv),
        .img_lv (img_lv),
        .beat   (beat)
    );

    img_capture_framer u_framer (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture      (capture),
        .header       (header),
        .beat         (beat),
        .full         (full),
        .push         (push),
        .push_data    (push_data),
        .capture_done (capture_done),
        .status       (status)
    );

    credit_word_sender u_sender (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .credit    (credit),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== src/img_ctrl_pkg.sv ====
`include "img_settings.svh"

package img_ctrl_pkg;

    // ========================================================================
    // Capture control
    // ========================================================================

    // Framer sequence
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_HEADER,
        ST_WAIT_IDLE,
        ST_WAIT_FRAME,
        ST_PIXELS,
        ST_CHECKSUM_LO,
        ST_CHECKSUM_HI
    } capture_state_t;

    // Results of the last capture
    typedef struct packed {
        logic [`IMG_COUNT_W-1:0] word_count;
        logic [`IMG_STAT_W-1:0]  highlight_count;
        logic [`IMG_STAT_W-1:0]  shadow_count;
        logic                    overflow;      // sticky, a pixel word was dropped
    } capture_status_t;

endpackage

// ==== src/img_data_pkg.sv ====
`include "img_settings.svh"

package img_data_pkg;

    // ========================================================================
    // Sensor and stream data
    // ========================================================================

    // One sensor sample
    typedef logic [11:0] pixel_t;

    // One word on the downstream link
    typedef logic [15:0] word_t;

    // Command header, sliced into stream words
    typedef logic [`IMG_HEADER_WORDS*16-1:0] header_t;

    // Registered sensor sample with its framing marks
    typedef struct packed {
        logic   valid;          // line valid
        logic   frame;          // frame valid
        logic   frame_rise;
        logic   frame_fall;
        logic   block_sample;   // first pixel of a 4x4 block
        pixel_t data;
    } pixel_beat_t;

endpackage

// ==== src/img_pixel_sampler.sv ====
`timescale 1ns/1ps

module img_pixel_sampler (
    input  logic                      clk,
    input  logic                      rst_n,
    input  img_data_pkg::pixel_t      img_d,
    input  logic                      img_fv,
    input  logic                      img_lv,
    output img_data_pkg::pixel_beat_t beat
);
    import img_data_pkg::*;

    // Position inside the current 4x4 block
    logic [1:0]  col;
    logic [1:0]  row;
    logic        frame_d;
    pixel_beat_t nxt;

    // Edge marks trail the beat that shows the change by one cycle
    always_comb begin
        nxt.valid        = img_lv;
        nxt.frame        = img_fv;
        nxt.frame_rise   = beat.frame && !frame_d;
        nxt.frame_fall   = !beat.frame && frame_d;
        nxt.block_sample = img_lv && (col == 2'd0) && (row == 2'd0);
        nxt.data         = img_d;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col     <= '0;
            row     <= '0;
            frame_d <= 1'b0;
            beat    <= '0;
        end else begin
            beat    <= nxt;
            frame_d <= beat.frame;
            col     <= img_lv ? col + 2'd1 : 2'd0;
            // Row steps when a line ends
            if (!img_fv) begin
                row <= '0;
            end else if (beat.valid && !img_lv) begin
                row <= row + 2'd1;
            end
        end
    end

endmodule

// ==== tests/tb_img_capture.sv ====
`timescale 1ns/1ps
`include "img_settings.svh"

module tb_img_capture;
    import img_data_pkg::*;
    import img_ctrl_pkg::*;

    localparam int HDR_BITS = $bits(header_t);
    // Pixels of all frames played by the tests
    localparam int FRAME_PIXELS = 8 * 8 + 8 * 8 + 16 * 16 + 4 * 4 + 8 * 8;
    localparam int TIMEOUT = FRAME_PIXELS * 4 + 2000;

    logic            clk;
    logic            rst_n;
    pixel_t          img_d;
    logic            img_fv;
    logic            img_lv;
    logic            capture;
    header_t         header;
    logic            out_valid;
    word_t           out_data;
    logic            credit = 1'b0;
    logic            capture_done;
    capture_status_t status;

    // Reference model and link monitor state
    pixel_t      frame_px [256];
    header_t     hdr;
    logic [15:0] exp_q [$];
    int          due_q [$];
    int          ref_s1;
    int          ref_s2;
    logic [15:0] exp_lo;
    logic [15:0] exp_hi;
    int          exp_high;
    int          exp_shadow;
    logic [15:0] last_word;
    logic [15:0] prev_word;
    int          recv_count = 0;
    int          errors = 0;
    int          cycle = 0;
    int          max_delay = 1;
    logic        credit_pause = 1'b0;
    logic [31:0] stim_rng = 32'hef47;
    logic [31:0] credit_rng = 32'hef47;
    string       cur_test = "reset";

    img_capture_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .img_d        (img_d),
        .img_fv       (img_fv),
        .img_lv       (img_lv),
        .capture      (capture),
        .header       (header),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .credit       (credit),
        .capture_done (capture_done),
        .status       (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // ========================================================================
    // Link monitor, credit returner and run limit
    // ========================================================================
    always @(posedge clk) begin
        credit <= 1'b0;
        if (rst_n) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: extra word %h arrived on the link", cur_test, out_data);
                end else begin
                    compare(cur_test, exp_q.pop_front(), out_data);
                end
                prev_word = last_word;
                last_word = out_data;
                recv_count++;
                credit_rng = xorshift(credit_rng);
                due_q.push_back(cycle + int'(credit_rng[7:0]) % (max_delay + 1));
            end
            // Oldest word gets its credit back first
            if (!credit_pause && due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                credit <= 1'b1;
            end
            if (due_q.size() > `IMG_CREDIT_MAX) begin
                errors++;
                $display("%s: more words received than credits allow", cur_test);
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("Run did not finish within %0d cycles", TIMEOUT);
            $display("Something failed");
            $finish;
        end
    end

    // ========================================================================
    // Stimulus and reference model
    // ========================================================================
    task automatic new_header();
        for (int i = 0; i < `IMG_HEADER_WORDS; i++) begin
            stim_rng = xorshift(stim_rng);
            hdr[16*i +: 16] = stim_rng[15:0];
        end
    endtask

    task automatic add_word(input logic [15:0] w);
        logic [15:0] sw;
        sw = {w[7:0], w[15:8]};
        exp_q.push_back(w);
        ref_s1 = (ref_s1 + sw) % 65535;
        ref_s2 = (ref_s2 + ref_s1) % 65535;
    endtask

    // Only the first keep pixels reach the link, stats see every sample
    task automatic build_expected(input int w, input int h, input int keep);
        pixel_t p;
        ref_s1 = 0;
        ref_s2 = 0;
        exp_high = 0;
        exp_shadow = 0;
        for (int i = 0; i < `IMG_HEADER_WORDS; i++) begin
            add_word(hdr[HDR_BITS-1-16*i -: 16]);
        end
        for (int i = 0; i < w * h; i++) begin
            p = frame_px[i];
            if (i < keep) begin
                add_word({p[7:0], 4'b0000, p[11:8]});
            end
            if ((i % w) % 4 == 0 && (i / w) % 4 == 0) begin
                if (p[11:5] == 7'h7f) begin
                    exp_high++;
                end else if (p[11:5] == 7'h00) begin
                    exp_shadow++;
                end
            end
        end
        exp_lo = {ref_s1[7:0], ref_s1[15:8]};
        exp_hi = {ref_s2[7:0], ref_s2[15:8]};
        exp_q.push_back(exp_lo);
        exp_q.push_back(exp_hi);
    endtask

    task automatic issue_capture();
        capture <= 1'b1;
        header  <= hdr;
        @(posedge clk);
        capture <= 1'b0;
    endtask

    // One idle cycle before the first line and between lines
    task automatic play_frame(input int w, input int h);
        img_fv <= 1'b1;
        @(posedge clk);
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                img_lv <= 1'b1;
                img_d  <= frame_px[y * w + x];
                @(posedge clk);
            end
            img_lv <= 1'b0;
            @(posedge clk);
        end
        img_fv <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_done();
        @(posedge clk);
        while (!capture_done) begin
            @(posedge clk);
        end
        // Done lasts a single cycle
        @(posedge clk);
        compare(cur_test, 0, capture_done);
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        while ((exp_q.size() != 0 || due_q.size() != 0) && n < 1000) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d expected words never arrived", name, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic run_capture(input string name, input int w, input int h);
        build_expected(w, h, w * h);
        issue_capture();
        repeat (16) @(posedge clk);
        play_frame(w, h);
        wait_done();
        wait_drain(name);
    endtask

    // ========================================================================
    // Tests
    // ========================================================================
    task automatic idle_after_reset();
        int base;
        cur_test <= "idle_after_reset";
        base = recv_count;
        repeat (50) @(posedge clk);
        compare("idle_after_reset", 0, recv_count - base);
        compare("idle_after_reset", 0, status);
    endtask

    task automatic stream_order_8x8();
        int base;
        cur_test <= "stream_order_8x8";
        new_header();
        for (int i = 0; i < 64; i++) begin
            frame_px[i] = pixel_t'(i * 157 + 53);
        end
        base = recv_count;
        run_capture("stream_order_8x8", 8, 8);
        compare("stream_order_8x8", `IMG_HEADER_WORDS + 66, status.word_count);
        compare("stream_order_8x8", `IMG_HEADER_WORDS + 66, recv_count - base);
        compare("stream_order_8x8", 0, status.overflow);
    endtask

    task automatic checksum_words();
        cur_test <= "checksum_words";
        new_header();
        for (int i = 0; i < 64; i++) begin
            stim_rng = xorshift(stim_rng);
            frame_px[i] = stim_rng[11:0];
        end
        run_capture("checksum_words", 8, 8);
        compare("checksum_words", exp_lo, prev_word);
        compare("checksum_words", exp_hi, last_word);
    endtask

    task automatic block_statistics();
        int x;
        int y;
        cur_test <= "block_statistics";
        new_header();
        for (int i = 0; i < 256; i++) begin
            x = i % 16;
            y = i / 16;
            stim_rng = xorshift(stim_rng);
            frame_px[i] = stim_rng[11:0];
            // Sample pixels cycle through saturated, black and mid grey
            if (x % 4 == 0 && y % 4 == 0) begin
                case ((x / 4 + y / 4) % 3)
                    0:       frame_px[i] = 12'hfe0 | pixel_t'(x);
                    1:       frame_px[i] = pixel_t'(y);
                    default: frame_px[i] = 12'h800;
                endcase
            end
        end
        run_capture("block_statistics", 16, 16);
        compare("block_statistics", exp_high, status.highlight_count);
        compare("block_statistics", exp_shadow, status.shadow_count);
    endtask

    task automatic random_credit_delays();
        int base;
        cur_test <= "random_credit_delays";
        max_delay <= 7;
        new_header();
        for (int i = 0; i < 16; i++) begin
            stim_rng = xorshift(stim_rng);
            frame_px[i] = stim_rng[11:0];
        end
        base = recv_count;
        build_expected(4, 4, 16);
        issue_capture();
        // Empty FIFO before the frame, so no pixel can be dropped
        while (recv_count < base + `IMG_HEADER_WORDS) begin
            @(posedge clk);
        end
        play_frame(4, 4);
        wait_done();
        wait_drain("random_credit_delays");
        compare("random_credit_delays", `IMG_HEADER_WORDS + 18, recv_count - base);
        compare("random_credit_delays", 0, status.overflow);
        max_delay <= 1;
    endtask

    task automatic overflow_with_paused_credits();
        int keep;
        cur_test <= "overflow_with_paused_credits";
        credit_pause <= 1'b1;
        new_header();
        for (int i = 0; i < 64; i++) begin
            frame_px[i] = pixel_t'(i * 41 + 7);
        end
        // The header spends the initial credits, the FIFO fills up with pixels
        keep = `IMG_FIFO_DEPTH + `IMG_CREDIT_MAX - `IMG_HEADER_WORDS;
        build_expected(8, 8, keep);
        issue_capture();
        repeat (16) @(posedge clk);
        play_frame(8, 8);
        repeat (4) @(posedge clk);
        compare("overflow_with_paused_credits", 1, status.overflow);
        credit_pause <= 1'b0;
        wait_done();
        compare("overflow_with_paused_credits", `IMG_HEADER_WORDS + keep + 2,
                status.word_count);
        wait_drain("overflow_with_paused_credits");
    endtask

    initial begin
        rst_n   = 1'b0;
        img_d   = '0;
        img_fv  = 1'b0;
        img_lv  = 1'b0;
        capture = 1'b0;
        header  = '0;
        hdr     = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        idle_after_reset();
        stream_order_8x8();
        checksum_words();
        block_statistics();
        random_credit_delays();
        overflow_with_paused_credits();

        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
